// ==== sources.f ====
+incdir+verilog
verilog/sched_pkg.sv
verilog/sched_ifs.sv
verilog/hash_queue.sv
verilog/slot_pool.sv
verilog/slot_pool_bank.sv
verilog/host_regs.sv
verilog/desc_allocator.sv
verilog/sched_top.sv
tb/tb_sched.sv

// ==== tb/tb_sched.sv ====
// Scheduler testbench
`timescale 1ns/1ps
`include "sched_cfg.svh"

module tb_sched;
  import sched_pkg::*;

  localparam int IFS       = `SCHED_IF_COUNT;
  localparam int CORES     = `SCHED_CORE_COUNT;
  localparam int N_ALLOC   = 24;
  localparam int N_REL     = 14;
  localparam int N_DROP    = 18;
  localparam int N_WAIT    = 9;
  localparam int NUM_TESTS = 6;
  localparam int LIMIT     = 200 * NUM_TESTS + 4 * (N_ALLOC + N_REL + N_DROP + N_WAIT);

  logic                   clk;
  logic                   rst_r;
  logic [IFS-1:0]         hash_valid;
  hash_t [IFS-1:0]        hash_value;
  line_count_t [IFS-1:0]  line_count;
  logic                   ctrl_valid;
  msg_type_e              ctrl_type;
  core_id_t               ctrl_core;
  slot_t                  ctrl_slot;
  logic [31:0]            host_cmd;
  logic [31:0]            host_wr_data;
  logic                   host_valid;
  logic [31:0]            host_rd_data;
  logic                   desc_valid;
  if_id_t                 desc_port;
  logic                   desc_drop;
  hash_t                  desc_hash;
  core_id_t               desc_core;
  slot_t                  desc_slot;

  // Reference model state
  hash_t       exp_hash [IFS][16];
  int          exp_head [IFS];
  int          exp_cnt [IFS];
  int          drop_model [IFS];
  logic [3:0]  mdl_slot [CORES][8];
  int          mdl_head [CORES];
  int          mdl_cnt [CORES];
  int          reserved [CORES];
  logic        exp_drop;
  logic        no_desc;

  logic [15:0] lfsr;
  int          errors;
  int          checks;
  int          cycles;
  int          test_num;
  int          test_err0;

  sched_top sched_top_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .hash_valid  (hash_valid),
    .hash_value  (hash_value),
    .line_count  (line_count),
    .ctrl_valid  (ctrl_valid),
    .ctrl_type   (ctrl_type),
    .ctrl_core   (ctrl_core),
    .ctrl_slot   (ctrl_slot),
    .host_cmd    (host_cmd),
    .host_wr_data(host_wr_data),
    .host_valid  (host_valid),
    .host_rd_data(host_rd_data),
    .desc_valid  (desc_valid),
    .desc_port   (desc_port),
    .desc_drop   (desc_drop),
    .desc_hash   (desc_hash),
    .desc_core   (desc_core),
    .desc_slot   (desc_slot)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int j = 0; j < n; j++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // First core from base onward that still has an unreserved slot
  function automatic int pick_core(input int base);
    int c;
    for (int k = 0; k < CORES; k++) begin
      c = (base + k) % CORES;
      if (mdl_cnt[c] - reserved[c] > 0) begin
        return c;
      end
    end
    return base;
  endfunction

  task automatic host_write(input logic [31:0] cmd, input logic [31:0] data);
    @(posedge clk);
    #2;
    host_cmd     = cmd;
    host_wr_data = data;
    host_valid   = 1'b1;
    @(posedge clk);
    #2;
    host_valid = 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic host_read_check(input logic [31:0] cmd, input logic [31:0] expected);
    logic [31:0] got;
    @(posedge clk);
    #2;
    host_cmd = cmd;
    repeat (3) @(posedge clk);
    #1;
    got = host_rd_data;
    @(posedge clk);
    checks++;
    if (got !== expected) begin
      $display("Mismatch host_rd_data: got %h expected %h for cmd %h", got, expected, cmd);
      errors++;
    end
  endtask

  task automatic send_ctrl(input msg_type_e t, input int core, input int slot);
    @(posedge clk);
    #2;
    ctrl_valid = 1'b1;
    ctrl_type  = t;
    ctrl_core  = core_id_t'(core);
    ctrl_slot  = slot_t'(slot);
    @(posedge clk);
    #2;
    ctrl_valid = 1'b0;
  endtask

  task automatic init_core(input int c, input int n);
    send_ctrl(MSG_SLOT_INIT, c, n);
    mdl_head[c] = 0;
    mdl_cnt[c]  = n;
    for (int k = 0; k < 8; k++) begin
      mdl_slot[c][k] = 4'(k + 1);
    end
  endtask

  task automatic send_hashes(input int n);
    int    sent;
    int    c;
    hash_t h;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      #2;
      hash_valid = '0;
      for (int i = 0; i < IFS; i++) begin
        if (rand_bits(1) != 0 && sent < n && exp_cnt[i] < 6) begin
          h = rand_bits(32);
          if (!exp_drop) begin
            c = pick_core(int'(h[1:0]));
            h[1:0] = 2'(c);
            reserved[c]++;
          end else begin
            drop_model[i]++;
          end
          hash_value[i] = h;
          hash_valid[i] = 1'b1;
          exp_hash[i][(exp_head[i] + exp_cnt[i]) % 16] = h;
          exp_cnt[i]++;
          sent++;
        end
      end
    end
    @(posedge clk);
    #2;
    hash_valid = '0;
  endtask

  task automatic wait_drain();
    while (exp_cnt[0] + exp_cnt[1] + exp_cnt[2] > 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic check_counts();
    for (int c = 0; c < CORES; c++) begin
      host_read_check(32'h3 | (c << 4), 32'(mdl_cnt[c]));
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("Test %0d %s: %s, %0d errors", test_num, name,
             (errors == test_err0) ? "ok" : "failed", errors - test_err0);
    test_err0 = errors;
  endtask

  // Each descriptor is matched against the oldest hash of its interface
  always @(negedge clk) begin : monitor
    int    p;
    int    c;
    hash_t h;
    if (!rst_r && desc_valid) begin
      checks++;
      p = int'(desc_port);
      if (no_desc) begin
        $display("Descriptor seen on interface %0d while no core accepts traffic", p);
        errors++;
      end
      if (p >= IFS || exp_cnt[p] == 0) begin
        $display("Unexpected descriptor on interface %0d with no hash pending", p);
        errors++;
      end else begin
        h = exp_hash[p][exp_head[p]];
        exp_head[p] = (exp_head[p] + 1) % 16;
        exp_cnt[p]--;
        c = int'(h[1:0]);
        if (desc_hash !== h) begin
          $display("Mismatch desc_hash: got %h expected %h", desc_hash, h);
          errors++;
        end
        if (desc_core !== h[1:0]) begin
          $display("Mismatch desc_core: got %h expected %h", desc_core, h[1:0]);
          errors++;
        end
        if (desc_drop !== exp_drop) begin
          $display("Mismatch desc_drop: got %h expected %h", desc_drop, exp_drop);
          errors++;
        end
        if (exp_drop) begin
          if (desc_slot !== '0) begin
            $display("Mismatch desc_slot: got %h expected 0", desc_slot);
            errors++;
          end
        end else begin
          reserved[c]--;
          if (mdl_cnt[c] == 0) begin
            $display("Core %0d allocated a slot it does not have", c);
            errors++;
          end else begin
            if (desc_slot !== mdl_slot[c][mdl_head[c]]) begin
              $display("Mismatch desc_slot: got %h expected %h", desc_slot,
                       mdl_slot[c][mdl_head[c]]);
              errors++;
            end
            mdl_head[c] = (mdl_head[c] + 1) % 8;
            mdl_cnt[c]--;
          end
        end
      end
    end
  end

  initial begin
    int c;
    int s;
    clk          = 1'b0;
    rst_r        = 1'b1;
    hash_valid   = '0;
    hash_value   = '0;
    line_count   = '0;
    ctrl_valid   = 1'b0;
    ctrl_type    = MSG_SLOT_RELEASE;
    ctrl_core    = '0;
    ctrl_slot    = '0;
    host_cmd     = '0;
    host_wr_data = '0;
    host_valid   = 1'b0;
    lfsr         = 16'd82;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    test_num     = 0;
    test_err0    = 0;
    exp_drop     = 1'b0;
    no_desc      = 1'b0;
    for (int i = 0; i < IFS; i++) begin
      exp_head[i]   = 0;
      exp_cnt[i]    = 0;
      drop_model[i] = 0;
    end
    for (int k = 0; k < CORES; k++) begin
      mdl_head[k] = 0;
      mdl_cnt[k]  = 0;
      reserved[k] = 0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_r = 1'b0;

    // Reset values and the income mask rule
    host_read_check(32'h0000_0000, 32'h0);
    host_read_check(32'h0000_0001, 32'h0);
    host_read_check(32'h0000_0005, `SCHED_RD_DEFAULT);
    host_write(32'hA000_0001, 32'hF);
    host_read_check(32'h0000_0001, 32'h0);
    host_write(32'hA000_0000, 32'hF);
    host_write(32'hA000_0001, 32'hF);
    host_read_check(32'h0000_0000, 32'hF);
    host_read_check(32'h0000_0001, 32'hF);
    host_write(32'hA000_0000, 32'h7);
    host_read_check(32'h0000_0001, 32'h7);
    host_write(32'hA000_0000, 32'hF);
    host_write(32'hA000_0001, 32'hF);
    host_read_check(32'h0000_0001, 32'hF);
    end_test("reset and config readback");

    for (int k = 0; k < CORES; k++) begin
      init_core(k, 8 - k);
    end
    repeat (3) @(posedge clk);
    check_counts();
    host_write(32'hA000_0002, 32'h2);
    mdl_cnt[1] = 0;
    host_read_check(32'h0000_0013, 32'h0);
    end_test("slot init and counts");

    for (int k = 0; k < CORES; k++) begin
      init_core(k, 8);
    end
    repeat (3) @(posedge clk);
    send_hashes(N_ALLOC);
    wait_drain();
    check_counts();
    end_test("random allocation");

    for (int k = 0; k < 10; k++) begin
      c = int'(rand_bits(2));
      for (int j = 0; j < CORES && mdl_cnt[c] >= 8; j++) begin
        c = (c + 1) % CORES;
      end
      s = int'(rand_bits(3)) + 1;
      send_ctrl(MSG_SLOT_RELEASE, c, s);
      mdl_slot[c][(mdl_head[c] + mdl_cnt[c]) % 8] = 4'(s);
      mdl_cnt[c]++;
    end
    repeat (3) @(posedge clk);
    check_counts();
    send_hashes(N_REL);
    wait_drain();
    check_counts();
    end_test("slot release");

    // Lines at or above a lowered limit with every core closed
    host_write(32'hA000_0001, 32'h0);
    host_write(32'hE000_0003, 32'd100);
    #2;
    line_count[0] = line_count_t'(100);
    line_count[1] = line_count_t'(100 + rand_bits(8));
    line_count[2] = line_count_t'(200 + rand_bits(8));
    repeat (3) @(posedge clk);
    exp_drop = 1'b1;
    send_hashes(N_DROP);
    wait_drain();
    exp_drop = 1'b0;
    for (int i = 0; i < IFS; i++) begin
      host_read_check(32'h4000_0002 | (i << 4), 32'(drop_model[i]));
    end
    end_test("drop path");

    #2;
    line_count = '0;
    for (int k = 0; k < CORES; k++) begin
      init_core(k, 8);
    end
    repeat (3) @(posedge clk);
    no_desc = 1'b1;
    send_hashes(N_WAIT);
    repeat (50) @(posedge clk);
    no_desc = 1'b0;
    host_write(32'hA000_0001, 32'hF);
    wait_drain();
    check_counts();
    end_test("wait path");

    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/desc_allocator.sv ====
// Slot allocation and drop decision
`timescale 1ns/1ps
`include "sched_cfg.svh"

module desc_allocator (
  input  logic                                         clk,
  input  logic                                         rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]                   queue_valid,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]       queue_hash,
  output logic [`SCHED_IF_COUNT-1:0]                   queue_pop,
  input  sched_pkg::line_count_t [`SCHED_IF_COUNT-1:0] line_count,
  host_cfg_if.cfg_dst                                  cfg,
  slot_pool_if.alloc                                   pools,
  output logic                                         desc_valid,
  output sched_pkg::if_id_t                            desc_port,
  output sched_pkg::sched_desc_t                       desc,
  output logic [`SCHED_IF_COUNT-1:0][31:0]             drop_counts
);
  import sched_pkg::*;

  localparam int IFS = `SCHED_IF_COUNT;

  line_count_t [IFS-1:0] line_r;
  logic [IFS-1:0]        almost_full;
  logic [IFS-1:0]        last_grant;
  logic [IFS-1:0]        req;
  if_id_t                rr_ptr;
  if_id_t                grant_idx;
  logic                  grant_v;
  logic                  sel_v_r;
  if_id_t                sel_idx_r;
  core_id_t              sel_core_r;
  logic                  slot_ok;
  logic                  take;
  logic                  drop;

  // The interface in stage 2 sits out one cycle until its pop lands
  assign req = queue_valid & ~last_grant;

  // Round robin starting at rr_ptr, lowest offset wins
  always_comb begin
    int k;
    grant_v   = 1'b0;
    grant_idx = '0;
    for (int i = IFS - 1; i >= 0; i--) begin
      k = (int'(rr_ptr) + i) % IFS;
      if (req[k]) begin
        grant_v   = 1'b1;
        grant_idx = if_id_t'(k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
      last_grant  <= '0;
      rr_ptr      <= '0;
      sel_v_r     <= 1'b0;
    end else begin
      for (int i = 0; i < IFS; i++) begin
        almost_full[i] <= (line_r[i] >= cfg.drop_limit);
      end
      sel_v_r    <= grant_v;
      last_grant <= '0;
      if (grant_v) begin
        last_grant[grant_idx] <= 1'b1;
        rr_ptr <= (grant_idx == if_id_t'(IFS - 1)) ? '0 : grant_idx + 1'b1;
      end
    end
  end

  // Core comes from the low hash bits
  always_ff @(posedge clk) begin
    line_r     <= line_count;
    sel_idx_r  <= grant_idx;
    sel_core_r <= core_id_t'(queue_hash[grant_idx]);
  end

  assign slot_ok = pools.head_valid[sel_core_r] && cfg.income_cores[sel_core_r];
  assign take    = sel_v_r && slot_ok;
  assign drop    = sel_v_r && !slot_ok && almost_full[sel_idx_r];

  // Without a slot or a full line the hash just waits at its queue head
  always_comb begin
    queue_pop = '0;
    pools.pop = '0;
    if (take || drop) begin
      queue_pop[sel_idx_r] = 1'b1;
    end
    if (take) begin
      pools.pop[sel_core_r] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      desc_valid <= 1'b0;
    end else begin
      desc_valid <= take || drop;
    end
  end

  always_ff @(posedge clk) begin
    desc_port    <= sel_idx_r;
    desc.drop    <= !slot_ok;
    desc.hash    <= queue_hash[sel_idx_r];
    desc.core    <= sel_core_r;
    desc.tag_pad <= '0;
    desc.slot    <= slot_ok ? pools.head_slot[sel_core_r] : '0;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_counts <= '0;
    end else if (drop) begin
      drop_counts[sel_idx_r] <= drop_counts[sel_idx_r] + 32'd1;
    end
  end

endmodule

// ==== verilog/hash_queue.sv ====
// Flow hash queue
`timescale 1ns/1ps

module hash_queue #(
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             push,
  input  sched_pkg::hash_t push_hash,
  input  logic             pop,
  output sched_pkg::hash_t head_hash,
  output logic             not_empty
);
  import sched_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  hash_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;

  assign full      = (count == (PTR_W+1)'(DEPTH));
  assign not_empty = (count != '0);
  assign head_hash = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_hash;
    end
  end

  // Pointers wrap naturally for a power-of-two depth
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  // Strobes arrive without back-pressure, so the queue must never overflow
  a_no_overflow: assert property (@(posedge clk) disable iff (rst_r) push |-> !full)
    else $error("hash_queue push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst_r) pop |-> not_empty)
    else $error("hash_queue pop while empty");

endmodule

// ==== verilog/host_regs.sv ====
// Host command registers
`timescale 1ns/1ps
`include "sched_cfg.svh"

module host_regs (
  input  logic                             clk,
  input  logic                             rst_r,
  input  logic [31:0]                      host_cmd,
  input  logic [31:0]                      host_wr_data,
  input  logic                             host_valid,
  output logic [31:0]                      host_rd_data,
  input  logic [`SCHED_IF_COUNT-1:0][31:0] drop_counts,
  host_cfg_if.cfg_src                      cfg,
  slot_pool_if.stat                        pools
);
  import sched_pkg::*;

  localparam int CORES = `SCHED_CORE_COUNT;
  localparam int IFS   = `SCHED_IF_COUNT;

  logic        wr_r;
  logic        to_if_r;
  logic [3:0]  reg_r;
  logic [3:0]  idx_r;
  logic [31:0] wr_data_r;
  logic [31:0] rd_data_n;

  // Bit 31 asks for a write and bit 29 confirms it
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r <= 1'b0;
    end else begin
      wr_r <= host_valid && host_cmd[31] && host_cmd[29];
    end
  end

  always_ff @(posedge clk) begin
    to_if_r   <= host_cmd[30];
    reg_r     <= host_cmd[3:0];
    idx_r     <= host_cmd[7:4];
    wr_data_r <= host_wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      cfg.enabled_cores <= '0;
      cfg.income_cores  <= '0;
      cfg.slots_flush   <= '0;
      cfg.drop_limit    <= line_count_t'(`SCHED_DROP_LIMIT_RST);
    end else begin
      cfg.slots_flush <= '0;
      if (wr_r) begin
        case ({to_if_r, reg_r})
          5'h00: begin
            // A disabled core can no longer take traffic
            cfg.income_cores  <= cfg.income_cores & wr_data_r[CORES-1:0];
            cfg.enabled_cores <= wr_data_r[CORES-1:0];
          end
          5'h01: cfg.income_cores <= wr_data_r[CORES-1:0] & cfg.enabled_cores;
          5'h02: cfg.slots_flush  <= wr_data_r[CORES-1:0];
          5'h13: cfg.drop_limit   <= wr_data_r[`SCHED_LINE_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Two register stages between the command and the read data
  always_ff @(posedge clk) begin
    case ({to_if_r, reg_r})
      5'h00: rd_data_n <= 32'(cfg.enabled_cores);
      5'h01: rd_data_n <= 32'(cfg.income_cores);
      5'h03: rd_data_n <= (idx_r < 4'(CORES)) ?
                          32'(pools.slot_count[core_id_t'(idx_r)]) : `SCHED_RD_DEFAULT;
      5'h12: rd_data_n <= (idx_r < 4'(IFS)) ?
                          drop_counts[if_id_t'(idx_r)] : `SCHED_RD_DEFAULT;
      default: rd_data_n <= `SCHED_RD_DEFAULT;
    endcase
    host_rd_data <= rd_data_n;
  end

endmodule

// ==== verilog/sched_cfg.svh ====
// Scheduler configuration
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// Receive interfaces and cores
`define SCHED_IF_COUNT 3
`define SCHED_CORE_COUNT 4

// Free slots per core and pending hashes per interface
`define SCHED_SLOT_COUNT 8
`define SCHED_HASH_DEPTH 8

// Receive line count width and its drop limit after reset
`define SCHED_LINE_W 13
`define SCHED_DROP_LIMIT_RST 3584

// Returned for registers that have no readback
`define SCHED_RD_DEFAULT 32'hFEFEFEFE

`endif

// ==== verilog/sched_ifs.sv ====
// Scheduler interfaces
`timescale 1ns/1ps
`include "sched_cfg.svh"

interface host_cfg_if;
  import sched_pkg::*;

  core_mask_t  enabled_cores;
  // Cores that accept new packets from the interfaces
  core_mask_t  income_cores;
  // One-cycle pulse per core
  core_mask_t  slots_flush;
  line_count_t drop_limit;

  modport cfg_src (
    output enabled_cores,
    output income_cores,
    output slots_flush,
    output drop_limit
  );

  modport cfg_dst (
    input enabled_cores,
    input income_cores,
    input slots_flush,
    input drop_limit
  );
endinterface

interface slot_pool_if;
  import sched_pkg::*;

  slot_t [`SCHED_CORE_COUNT-1:0] head_slot;
  core_mask_t                    head_valid;
  // One-hot, only while the matching head is valid
  core_mask_t                    pop;
  slot_t [`SCHED_CORE_COUNT-1:0] slot_count;

  modport pool  (output head_slot, output head_valid, output slot_count, input pop);
  modport alloc (input head_slot, input head_valid, output pop);
  modport stat  (input slot_count);
endinterface

// ==== verilog/sched_pkg.sv ====
// Scheduler shared types
`include "sched_cfg.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0]   core_id_t;
  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0]     if_id_t;
  // Wide enough for a slot number and for a full count
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;
  typedef logic [31:0]                            hash_t;
  typedef logic [`SCHED_LINE_W-1:0]               line_count_t;
  typedef logic [`SCHED_CORE_COUNT-1:0]           core_mask_t;

  // Core control messages, other codes are ignored
  typedef enum logic [3:0] {
    MSG_SLOT_RELEASE = 4'd0,
    MSG_SLOT_INIT    = 4'd3
  } msg_type_e;

  // Slot sits in a 6-bit tag whose upper bits stay zero
  typedef struct packed {
    logic       drop;
    hash_t      hash;
    core_id_t   core;
    logic [1:0] tag_pad;
    slot_t      slot;
  } sched_desc_t;

endpackage

// ==== verilog/sched_top.sv ====
// Packet scheduler top level
`timescale 1ns/1ps
`include "sched_cfg.svh"

module sched_top (
  input  logic                                         clk,
  input  logic                                         rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]                   hash_valid,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]       hash_value,
  input  sched_pkg::line_count_t [`SCHED_IF_COUNT-1:0] line_count,
  input  logic                                         ctrl_valid,
  input  sched_pkg::msg_type_e                         ctrl_type,
  input  sched_pkg::core_id_t                          ctrl_core,
  input  sched_pkg::slot_t                             ctrl_slot,
  input  logic [31:0]                                  host_cmd,
  input  logic [31:0]                                  host_wr_data,
  input  logic                                         host_valid,
  output logic [31:0]                                  host_rd_data,
  output logic                                         desc_valid,
  output sched_pkg::if_id_t                            desc_port,
  output logic                                         desc_drop,
  output sched_pkg::hash_t                             desc_hash,
  output sched_pkg::core_id_t                          desc_core,
  output sched_pkg::slot_t                             desc_slot
);
  import sched_pkg::*;

  localparam int IFS = `SCHED_IF_COUNT;

  logic [IFS-1:0]       queue_valid;
  logic [IFS-1:0]       queue_pop;
  hash_t [IFS-1:0]      queue_hash;
  logic [IFS-1:0][31:0] drop_counts;
  sched_desc_t          desc;
  logic                 slot_err;

  host_cfg_if  cfg_if ();
  slot_pool_if pool_if ();

  for (genvar i = 0; i < IFS; i++) begin : g_queue
    hash_queue #(
      .DEPTH(`SCHED_HASH_DEPTH)
    ) queue_inst (
      .clk      (clk),
      .rst_r    (rst_r),
      .push     (hash_valid[i]),
      .push_hash(hash_value[i]),
      .pop      (queue_pop[i]),
      .head_hash(queue_hash[i]),
      .not_empty(queue_valid[i])
    );
  end

  slot_pool_bank bank_inst (
    .clk       (clk),
    .rst_r     (rst_r),
    .ctrl_valid(ctrl_valid),
    .ctrl_type (ctrl_type),
    .ctrl_core (ctrl_core),
    .ctrl_slot (ctrl_slot),
    .cfg       (cfg_if.cfg_dst),
    .pools     (pool_if.pool),
    .slot_err  (slot_err)
  );

  host_regs regs_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .host_cmd    (host_cmd),
    .host_wr_data(host_wr_data),
    .host_valid  (host_valid),
    .host_rd_data(host_rd_data),
    .drop_counts (drop_counts),
    .cfg         (cfg_if.cfg_src),
    .pools       (pool_if.stat)
  );

  desc_allocator alloc_inst (
    .clk        (clk),
    .rst_r      (rst_r),
    .queue_valid(queue_valid),
    .queue_hash (queue_hash),
    .queue_pop  (queue_pop),
    .line_count (line_count),
    .cfg        (cfg_if.cfg_dst),
    .pools      (pool_if.alloc),
    .desc_valid (desc_valid),
    .desc_port  (desc_port),
    .desc       (desc),
    .drop_counts(drop_counts)
  );

  assign desc_drop = desc.drop;
  assign desc_hash = desc.hash;
  assign desc_core = desc.core;
  assign desc_slot = desc.slot;

endmodule

// ==== verilog/slot_pool.sv ====
// Per-core free slot pool
`timescale 1ns/1ps

module slot_pool #(
  parameter int SLOT_COUNT = 8
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             flush,
  input  logic             init_valid,
  input  sched_pkg::slot_t init_count,
  input  logic             release_valid,
  input  sched_pkg::slot_t release_slot,
  input  logic             pop,
  output sched_pkg::slot_t head_slot,
  output logic             head_valid,
  output sched_pkg::slot_t slot_count,
  output logic             enq_err
);
  import sched_pkg::*;

  localparam int PTR_W = $clog2(SLOT_COUNT);

  slot_t            mem [SLOT_COUNT];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  slot_t            count;
  logic             full;
  logic             rel_ok;

  assign full       = (count == slot_t'(SLOT_COUNT));
  assign rel_ok     = release_valid && !full;
  assign head_slot  = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign slot_count = count;

  // Init fills every entry, only the first init_count of them count as free
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (rel_ok) begin
      mem[wr_ptr] <= release_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_count[PTR_W-1:0];
      count  <= init_count;
    end else begin
      if (rel_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + slot_t'(rel_ok) - slot_t'(pop);
    end
  end

  // Sticky until reset or flush
  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      enq_err <= 1'b0;
    end else if (release_valid && full) begin
      enq_err <= 1'b1;
    end
  end

  a_pop_valid: assert property (@(posedge clk) disable iff (rst_r) pop |-> head_valid)
    else $error("slot_pool pop without a free slot");

  a_no_overflow: assert property (@(posedge clk) disable iff (rst_r) release_valid |-> !full)
    else $error("slot_pool release into a full pool");

endmodule

// ==== verilog/slot_pool_bank.sv ====
// Slot pools of all cores
`timescale 1ns/1ps
`include "sched_cfg.svh"

module slot_pool_bank (
  input  logic                 clk,
  input  logic                 rst_r,
  input  logic                 ctrl_valid,
  input  sched_pkg::msg_type_e ctrl_type,
  input  sched_pkg::core_id_t  ctrl_core,
  input  sched_pkg::slot_t     ctrl_slot,
  host_cfg_if.cfg_dst          cfg,
  slot_pool_if.pool            pools,
  output logic                 slot_err
);
  import sched_pkg::*;

  localparam int CORES = `SCHED_CORE_COUNT;

  core_mask_t init_v;
  core_mask_t rel_v;
  slot_t      msg_slot;
  core_mask_t pool_err;

  // Message decode is registered to keep the pool inputs short
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v <= '0;
      rel_v  <= '0;
    end else begin
      for (int i = 0; i < CORES; i++) begin
        init_v[i] <= ctrl_valid && (ctrl_type == MSG_SLOT_INIT) &&
                     (ctrl_core == core_id_t'(i));
        rel_v[i]  <= ctrl_valid && (ctrl_type == MSG_SLOT_RELEASE) &&
                     (ctrl_core == core_id_t'(i));
      end
    end
  end

  // Slot number doubles as the init count
  always_ff @(posedge clk) begin
    msg_slot <= ctrl_slot;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      slot_err <= 1'b0;
    end else begin
      slot_err <= |pool_err;
    end
  end

  for (genvar i = 0; i < CORES; i++) begin : g_pool
    slot_pool #(
      .SLOT_COUNT(`SCHED_SLOT_COUNT)
    ) pool_inst (
      .clk          (clk),
      .rst_r        (rst_r),
      .flush        (cfg.slots_flush[i]),
      .init_valid   (init_v[i]),
      .init_count   (msg_slot),
      .release_valid(rel_v[i]),
      .release_slot (msg_slot),
      .pop          (pools.pop[i]),
      .head_slot    (pools.head_slot[i]),
      .head_valid   (pools.head_valid[i]),
      .slot_count   (pools.slot_count[i]),
      .enq_err      (pool_err[i])
    );
  end

endmodule
